// ==== design/cpu_pkg.sv ====
package cpu_pkg;
	localparam int DATA_W = 32;

	// Instruction word layout
	localparam int OP_LSB = 27;
	localparam int RA_LSB = 23;
	localparam int RB_LSB = 19;
	localparam int RC_LSB = 15;
	localparam int REG_FIELD_W = 4;
	localparam int C_W = 19;

	typedef enum logic [4:0] {
		OP_LD = 5'd0,
		OP_LDI = 5'd1,
		OP_ST = 5'd2,
		OP_ADD = 5'd3,
		OP_SUB = 5'd4,
		OP_AND = 5'd5,
		OP_OR = 5'd6,
		OP_ADDI = 5'd12,
		OP_HALT = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR
	} alu_op_t;

	// One step of the instruction cycle
	typedef enum logic [2:0] {
		T0, T1, T2, T3, T4, T5, T6, T_HALT
	} tstate_t;

	function automatic opcode_t get_opcode(input logic [DATA_W-1:0] instr);
		return opcode_t'(instr[DATA_W-1:OP_LSB]);
	endfunction

	function automatic logic [REG_FIELD_W-1:0] get_ra(input logic [DATA_W-1:0] instr);
		return instr[RA_LSB +: REG_FIELD_W];
	endfunction

	function automatic logic [REG_FIELD_W-1:0] get_rb(input logic [DATA_W-1:0] instr);
		return instr[RB_LSB +: REG_FIELD_W];
	endfunction

	function automatic logic [REG_FIELD_W-1:0] get_rc(input logic [DATA_W-1:0] instr);
		return instr[RC_LSB +: REG_FIELD_W];
	endfunction

	// C constant, sign-extended to a full word
	function automatic logic [DATA_W-1:0] sext_c(input logic [DATA_W-1:0] instr);
		return {{(DATA_W - C_W){instr[C_W-1]}}, instr[C_W-1:0]};
	endfunction
endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// Only the two codes the slaves here can return
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;
endpackage

// ==== design/cpu_ifs.sv ====
// Control word from the sequencer to the datapath
interface dp_ctrl_if;
	// Register load enables
	logic pc_en, pc_inc, ir_en, y_en, z_en, mar_en, mdr_en, r_en;
	// Bus source selects, one-hot
	logic pc_out, mdr_out, zlo_out, c_out, r_out;
	// Register field selection
	logic gra, grb, grc, ba_out;
	cpu_pkg::alu_op_t alu_op;
	logic read, write;
	// Status back to the sequencer
	logic [cpu_pkg::DATA_W-1:0] ir;
	logic mem_done;

	modport seq (
		output pc_en, pc_inc, ir_en, y_en, z_en, mar_en, mdr_en, r_en,
		output pc_out, mdr_out, zlo_out, c_out, r_out,
		output gra, grb, grc, ba_out, alu_op, read, write,
		input ir, mem_done
	);

	modport dp (
		input pc_en, pc_inc, ir_en, y_en, z_en, mar_en, mdr_en, r_en,
		input pc_out, mdr_out, zlo_out, c_out, r_out,
		input gra, grb, grc, ba_out, alu_op, read, write,
		output ir, mem_done
	);
endinterface

// MAR/MDR requests toward the bus bridge
interface mem_req_if;
	logic [cpu_pkg::DATA_W-1:0] addr;
	logic [cpu_pkg::DATA_W-1:0] wdata;
	logic read, write;
	logic [cpu_pkg::DATA_W-1:0] rdata;
	// One-cycle pulse, request drops after it
	logic done;

	modport dp (output addr, wdata, read, write, input rdata, done);
	modport bridge (input addr, wdata, read, write, output rdata, done);
endinterface

// ==== design/alu.sv ====
module alu (
	input cpu_pkg::alu_op_t op,
	input logic [cpu_pkg::DATA_W-1:0] a,
	input logic [cpu_pkg::DATA_W-1:0] b,
	output logic [cpu_pkg::DATA_W-1:0] result
);
	// a is Y, b is whatever sits on the bus
	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR: result = a | b;
			default: result = b;
		endcase
	end
endmodule

// ==== design/reg_file.sv ====
module reg_file #(
	parameter int NUM_REGS = 16
) (
	input logic clk,
	input logic rst_n,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic ba_out,
	input logic r_en,
	input logic [cpu_pkg::DATA_W-1:0] ir,
	input logic [cpu_pkg::DATA_W-1:0] bus_in,
	output logic [cpu_pkg::DATA_W-1:0] r_data
);
	localparam int IDX_W = $clog2(NUM_REGS);

	logic [cpu_pkg::DATA_W-1:0] regs [NUM_REGS];
	logic [cpu_pkg::REG_FIELD_W-1:0] field;
	logic [IDX_W-1:0] idx;

	// Only one of gra/grb/grc is high at a time
	assign field = ({cpu_pkg::REG_FIELD_W{gra}} & cpu_pkg::get_ra(ir))
		| ({cpu_pkg::REG_FIELD_W{grb}} & cpu_pkg::get_rb(ir))
		| ({cpu_pkg::REG_FIELD_W{grc}} & cpu_pkg::get_rc(ir));
	assign idx = IDX_W'(field);

	// R0 acts as a zero base under BAout
	assign r_data = (ba_out && idx == '0) ? '0 : regs[idx];

	always_ff @(posedge clk) begin
		if (rst_n && r_en) regs[idx] <= bus_in;
	end
endmodule

// ==== design/datapath.sv ====
module datapath #(
	parameter int NUM_REGS = 16,
	parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	dp_ctrl_if.dp ctrl,
	mem_req_if.dp mem
);
	localparam int W = cpu_pkg::DATA_W;

	logic [W-1:0] pc, ir, y, z, mar, mdr;
	logic [W-1:0] bus, c_ext, r_data, alu_result;

	assign c_ext = cpu_pkg::sext_c(ir);

	// Selects are one-hot, so an AND-OR mux is enough
	assign bus = ({W{ctrl.pc_out}} & pc)
		| ({W{ctrl.mdr_out}} & mdr)
		| ({W{ctrl.zlo_out}} & z)
		| ({W{ctrl.c_out}} & c_ext)
		| ({W{ctrl.r_out}} & r_data);

	reg_file #(
		.NUM_REGS(NUM_REGS)
	) reg_file_i (
		.clk(clk),
		.rst_n(rst_n),
		.gra(ctrl.gra),
		.grb(ctrl.grb),
		.grc(ctrl.grc),
		.ba_out(ctrl.ba_out),
		.r_en(ctrl.r_en),
		.ir(ir),
		.bus_in(bus),
		.r_data(r_data)
	);

	alu alu_i (
		.op(ctrl.alu_op),
		.a(y),
		.b(bus),
		.result(alu_result)
	);

	// No jump instructions yet, so pc_en stays low in practice
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (ctrl.pc_en) begin
			pc <= bus;
		end else if (ctrl.pc_inc) begin
			pc <= pc + W'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.ir_en) ir <= bus;
		if (ctrl.y_en) y <= bus;
		if (ctrl.z_en) z <= alu_result;
		if (ctrl.mar_en) mar <= bus;
		// On a read MDR waits for the bridge, otherwise it takes the bus
		if (ctrl.mdr_en && (!ctrl.read || mem.done)) mdr <= ctrl.read ? mem.rdata : bus;
	end

	assign mem.addr = mar;
	assign mem.wdata = mdr;
	assign mem.read = ctrl.read;
	assign mem.write = ctrl.write;

	assign ctrl.ir = ir;
	assign ctrl.mem_done = mem.done;
endmodule

// ==== design/control_sequencer.sv ====
module control_sequencer (
	input logic clk,
	input logic rst_n,
	dp_ctrl_if.seq ctrl,
	output logic halted
);
	cpu_pkg::tstate_t state, state_nxt;
	// Second phase inside a state: PC already bumped, MDR loaded, load data ready
	logic sub, sub_nxt;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_op_t alu_sel;
	logic is_alu, is_imm, is_mem;

	assign opcode = cpu_pkg::get_opcode(ctrl.ir);
	assign is_alu = opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR};
	assign is_imm = opcode inside {cpu_pkg::OP_LDI, cpu_pkg::OP_ADDI};
	assign is_mem = opcode inside {cpu_pkg::OP_LD, cpu_pkg::OP_ST};
	assign halted = (state == cpu_pkg::T_HALT);

	always_comb begin
		case (opcode)
			cpu_pkg::OP_SUB: alu_sel = cpu_pkg::ALU_SUB;
			cpu_pkg::OP_AND: alu_sel = cpu_pkg::ALU_AND;
			cpu_pkg::OP_OR: alu_sel = cpu_pkg::ALU_OR;
			default: alu_sel = cpu_pkg::ALU_ADD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu_pkg::T0;
			sub <= 1'b0;
		end else begin
			state <= state_nxt;
			sub <= sub_nxt;
		end
	end

	always_comb begin
		ctrl.pc_en = 1'b0;
		ctrl.pc_inc = 1'b0;
		ctrl.ir_en = 1'b0;
		ctrl.y_en = 1'b0;
		ctrl.z_en = 1'b0;
		ctrl.mar_en = 1'b0;
		ctrl.mdr_en = 1'b0;
		ctrl.r_en = 1'b0;
		ctrl.pc_out = 1'b0;
		ctrl.mdr_out = 1'b0;
		ctrl.zlo_out = 1'b0;
		ctrl.c_out = 1'b0;
		ctrl.r_out = 1'b0;
		ctrl.gra = 1'b0;
		ctrl.grb = 1'b0;
		ctrl.grc = 1'b0;
		ctrl.ba_out = 1'b0;
		ctrl.alu_op = cpu_pkg::ALU_PASS_B;
		ctrl.read = 1'b0;
		ctrl.write = 1'b0;
		state_nxt = state;
		sub_nxt = sub;
		case (state)
			cpu_pkg::T0: begin
				ctrl.pc_out = 1'b1;
				ctrl.mar_en = 1'b1;
				state_nxt = cpu_pkg::T1;
			end
			cpu_pkg::T1: begin
				// PC bumps once, on the first cycle only
				ctrl.pc_inc = !sub;
				ctrl.read = 1'b1;
				ctrl.mdr_en = 1'b1;
				sub_nxt = 1'b1;
				if (ctrl.mem_done) state_nxt = cpu_pkg::T2;
			end
			cpu_pkg::T2: begin
				ctrl.mdr_out = 1'b1;
				ctrl.ir_en = 1'b1;
				state_nxt = cpu_pkg::T3;
			end
			cpu_pkg::T3: begin
				// Unknown opcodes stop the CPU like halt
				if (is_alu || is_imm || is_mem) begin
					ctrl.grb = 1'b1;
					ctrl.ba_out = !is_alu;
					ctrl.r_out = 1'b1;
					ctrl.y_en = 1'b1;
					state_nxt = cpu_pkg::T4;
				end else begin
					state_nxt = cpu_pkg::T_HALT;
				end
			end
			cpu_pkg::T4: begin
				ctrl.z_en = 1'b1;
				if (is_alu) begin
					ctrl.grc = 1'b1;
					ctrl.r_out = 1'b1;
					ctrl.alu_op = alu_sel;
				end else begin
					ctrl.c_out = 1'b1;
					ctrl.alu_op = cpu_pkg::ALU_ADD;
				end
				state_nxt = cpu_pkg::T5;
			end
			cpu_pkg::T5: begin
				ctrl.zlo_out = 1'b1;
				if (is_mem) begin
					ctrl.mar_en = 1'b1;
					state_nxt = cpu_pkg::T6;
				end else begin
					ctrl.gra = 1'b1;
					ctrl.r_en = 1'b1;
					state_nxt = cpu_pkg::T0;
				end
			end
			cpu_pkg::T6: begin
				if (opcode == cpu_pkg::OP_ST) begin
					if (!sub) begin
						// Ra into MDR before the write goes out
						ctrl.gra = 1'b1;
						ctrl.r_out = 1'b1;
						ctrl.mdr_en = 1'b1;
						sub_nxt = 1'b1;
					end else begin
						ctrl.write = 1'b1;
						if (ctrl.mem_done) state_nxt = cpu_pkg::T0;
					end
				end else if (!sub) begin
					ctrl.read = 1'b1;
					ctrl.mdr_en = 1'b1;
					if (ctrl.mem_done) sub_nxt = 1'b1;
				end else begin
					ctrl.mdr_out = 1'b1;
					ctrl.gra = 1'b1;
					ctrl.r_en = 1'b1;
					state_nxt = cpu_pkg::T0;
				end
			end
			default: state_nxt = cpu_pkg::T_HALT;
		endcase
		if (state_nxt != state) sub_nxt = 1'b0;
	end
endmodule

// ==== design/mem_bridge.sv ====
module mem_bridge (
	input logic clk,
	input logic rst_n,
	mem_req_if.bridge mem,
	output logic [bus_pkg::AXI_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output logic [bus_pkg::AXI_DATA_W-1:0] wdata,
	output logic [bus_pkg::AXI_STRB_W-1:0] wstrb,
	output logic wvalid,
	input logic wready,
	input bus_pkg::resp_t bresp,
	input logic bvalid,
	output logic bready,
	output logic [bus_pkg::AXI_ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input logic [bus_pkg::AXI_DATA_W-1:0] rdata,
	input bus_pkg::resp_t rresp,
	input logic rvalid,
	output logic rready
);
	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_RESP
	} state_t;

	state_t state;
	logic is_write;
	// AW or W channel taken, either earlier or in this cycle
	logic aw_ok, w_ok;

	assign aw_ok = !awvalid || awready;
	assign w_ok = !wvalid || wready;

	// Full-word writes only
	assign wstrb = '1;
	assign bready = (state == S_RESP) && is_write;
	assign rready = (state == S_RESP) && !is_write;

	// bresp and rresp are not checked. SLVERR completes like OKAY, rdata as is
	assign mem.done = (state == S_RESP) && (is_write ? bvalid : rvalid);
	assign mem.rdata = rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			is_write <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (mem.write) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						is_write <= 1'b1;
						state <= S_ADDR;
					end else if (mem.read) begin
						arvalid <= 1'b1;
						is_write <= 1'b0;
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					if (awready) awvalid <= 1'b0;
					if (wready) wvalid <= 1'b0;
					if (arready) arvalid <= 1'b0;
					if (is_write ? (aw_ok && w_ok) : arready) state <= S_RESP;
				end
				S_RESP: begin
					if (mem.done) state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Payload follows the request until it leaves idle, then holds
	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			awaddr <= mem.addr;
			araddr <= mem.addr;
			wdata <= mem.wdata;
		end
	end
endmodule

// ==== design/cpu_top.sv ====
module cpu_top #(
	parameter int NUM_REGS = 16,
	parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	output logic [bus_pkg::AXI_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output logic [bus_pkg::AXI_DATA_W-1:0] wdata,
	output logic [bus_pkg::AXI_STRB_W-1:0] wstrb,
	output logic wvalid,
	input logic wready,
	input bus_pkg::resp_t bresp,
	input logic bvalid,
	output logic bready,
	output logic [bus_pkg::AXI_ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input logic [bus_pkg::AXI_DATA_W-1:0] rdata,
	input bus_pkg::resp_t rresp,
	input logic rvalid,
	output logic rready,
	output logic halted
);
	dp_ctrl_if ctrl_bus ();
	mem_req_if mem_req ();

	control_sequencer sequencer_i (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl_bus.seq),
		.halted(halted)
	);

	datapath #(
		.NUM_REGS(NUM_REGS),
		.RESET_PC(RESET_PC)
	) datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl_bus.dp),
		.mem(mem_req.dp)
	);

	mem_bridge mem_bridge_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem(mem_req.bridge),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);
endmodule

// ==== verif/cpu_chk.sv ====
module cpu_chk (
	input logic clk,
	input logic rst_n,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready
);
	timeunit 1ns;
	timeprecision 100ps;

	// A transaction is open from its first valid to its response
	logic busy;

	always_ff @(posedge clk) begin
		if (!rst_n)
			busy <= 1'b0;
		else if ((rvalid && rready) || (bvalid && bready))
			busy <= 1'b0;
		else if (arvalid || awvalid || wvalid)
			busy <= 1'b1;
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");
	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before awready");
	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("wvalid or wdata changed before wready");
	one_open: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(arvalid) || $rose(awvalid) |-> !busy)
		else $error("new request started before the previous one completed");
endmodule

bind mem_bridge cpu_chk cpu_chk_i (
	.clk(clk), .rst_n(rst_n),
	.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
	.wdata(wdata), .wvalid(wvalid), .wready(wready),
	.bvalid(bvalid), .bready(bready),
	.araddr(araddr), .arvalid(arvalid), .arready(arready),
	.rvalid(rvalid), .rready(rready)
);

// ==== verif/cpu_scoreboard.sv ====
module cpu_scoreboard #(
	parameter logic [31:0] RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic halted
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] model_mem [logic [29:0]];
	logic [31:0] exp_raddr[$];
	logic [31:0] exp_waddr[$];
	logic [31:0] exp_wdata[$];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors;
	int reads_seen;
	int writes_seen;
	logic late_seen;

	task automatic clear_model();
		model_mem.delete();
	endtask

	task automatic set_word(input logic [31:0] a, input logic [31:0] w);
		model_mem[a[31:2]] = w;
	endtask

	function automatic logic [31:0] get_word(input logic [31:0] a);
		if (model_mem.exists(a[31:2]))
			return model_mem[a[31:2]];
		return '0;
	endfunction

	// Instruction-set model, builds the expected AXI traffic up front
	task automatic start_test();
		logic [31:0] regs [16];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] c;
		logic [31:0] base;
		logic [31:0] addr;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic stop;
		exp_raddr.delete();
		exp_waddr.delete();
		exp_wdata.delete();
		test_errors = 0;
		reads_seen = 0;
		writes_seen = 0;
		late_seen = 1'b0;
		pc = RESET_PC;
		stop = 1'b0;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int step = 0; step < 1000 && !stop; step++) begin
			exp_raddr.push_back(pc);
			ins = get_word(pc);
			pc = pc + 32'd4;
			ra = ins[26:23];
			rb = ins[22:19];
			rc = ins[18:15];
			c = {{13{ins[18]}}, ins[18:0]};
			// R0 counts as zero when used as a base
			base = (rb == 4'd0) ? 32'd0 : regs[rb];
			addr = base + c;
			case (ins[31:27])
				cpu_pkg::OP_LDI, cpu_pkg::OP_ADDI: regs[ra] = addr;
				cpu_pkg::OP_ADD: regs[ra] = regs[rb] + regs[rc];
				cpu_pkg::OP_SUB: regs[ra] = regs[rb] - regs[rc];
				cpu_pkg::OP_AND: regs[ra] = regs[rb] & regs[rc];
				cpu_pkg::OP_OR: regs[ra] = regs[rb] | regs[rc];
				cpu_pkg::OP_LD: begin
					exp_raddr.push_back(addr);
					regs[ra] = get_word(addr);
				end
				cpu_pkg::OP_ST: begin
					exp_waddr.push_back(addr);
					exp_wdata.push_back(regs[ra]);
					model_mem[addr[31:2]] = regs[ra];
				end
				default: stop = 1'b1;
			endcase
		end
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
		end
	endtask

	task automatic fail_plain(input string what);
		errors++;
		test_errors++;
		$display("At %0t: %s", $time, what);
	endtask

	// Outputs while reset is still held
	task automatic check_reset();
		compare("halted", 32'd0, 32'(halted));
		compare("arvalid", 32'd0, 32'(arvalid));
		compare("awvalid", 32'd0, 32'(awvalid));
		compare("wvalid", 32'd0, 32'(wvalid));
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (arvalid && arready) begin
				reads_seen++;
				if (exp_raddr.size() == 0)
					fail_plain("read request that the model does not expect");
				else
					compare("araddr", exp_raddr.pop_front(), araddr);
			end
			if (awvalid && awready) begin
				writes_seen++;
				if (exp_waddr.size() == 0)
					fail_plain("write address that the model does not expect");
				else
					compare("awaddr", exp_waddr.pop_front(), awaddr);
			end
			if (wvalid && wready) begin
				// Only full-word writes exist
				compare("wstrb", 32'h0000_000f, 32'(wstrb));
				if (exp_wdata.size() == 0)
					fail_plain("write data that the model does not expect");
				else
					compare("wdata", exp_wdata.pop_front(), wdata);
			end
			// A response only comes after the request was accepted
			if (rvalid)
				compare("rready", 32'd1, 32'(rready));
			if (bvalid)
				compare("bready", 32'd1, 32'(bready));
			if (halted && !late_seen && (arvalid || awvalid || wvalid)) begin
				late_seen = 1'b1;
				fail_plain("an AXI request started after halted rose");
			end
		end
	end

	task automatic end_test(input int n);
		if (exp_raddr.size() != 0 || exp_waddr.size() != 0 || exp_wdata.size() != 0)
			fail_plain("the CPU halted before all expected transfers were seen");
		tests++;
		$display("Test %0d: %0d reads, %0d writes, %0d errors",
			n, reads_seen, writes_seen, test_errors);
	endtask

	task automatic report();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
	endtask
endmodule

// ==== verif/cpu_tb.sv ====
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam logic [31:0] DATA_BASE = 32'h0000_1000;
	localparam logic [31:0] DUMP_BASE = 32'h0000_2000;
	localparam int NUM_TESTS = 4;
	localparam int RAND_LEN = 24;

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready, halted;
	bus_pkg::resp_t bresp, rresp;

	int seed = 32'hd0deb748;
	logic timed_out = 1'b0;
	int prog_len;
	int limit;
	int cycles;
	logic [31:0] mem_words [logic [29:0]];

	always #20 clk = ~clk;

	cpu_top #(.NUM_REGS(16), .RESET_PC(RESET_PC)) cpu_top_i (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.halted(halted)
	);

	cpu_scoreboard #(.RESET_PC(RESET_PC)) scoreboard_i (
		.clk(clk), .rst_n(rst_n),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
		.halted(halted)
	);

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Unwritten words read back a pattern built from the full address
	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (mem_words.exists(a[31:2]))
			return mem_words[a[31:2]];
		return (a * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	task automatic put_word(input logic [31:0] a, input logic [31:0] w);
		mem_words[a[31:2]] = w;
		scoreboard_i.set_word(a, w);
	endtask

	// Init all registers, random body, dump all registers, halt
	task automatic build_program(output int n);
		logic [31:0] a;
		logic [31:0] r;
		logic [4:0] op;
		int k;
		mem_words.delete();
		scoreboard_i.clear_model();
		a = RESET_PC;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			put_word(a, {cpu_pkg::OP_LDI, 4'(i), 4'd0, r[18:0]});
			a = a + 32'd4;
		end
		for (int i = 0; i < RAND_LEN; i++) begin
			r = $random(seed);
			k = rand_below(16);
			case (rand_below(8))
				0: op = cpu_pkg::OP_LDI;
				1: op = cpu_pkg::OP_ADDI;
				2: op = cpu_pkg::OP_LD;
				3: op = cpu_pkg::OP_ST;
				4: op = cpu_pkg::OP_ADD;
				5: op = cpu_pkg::OP_SUB;
				6: op = cpu_pkg::OP_AND;
				default: op = cpu_pkg::OP_OR;
			endcase
			if (op == cpu_pkg::OP_LD || op == cpu_pkg::OP_ST)
				put_word(a, {op, r[26:23], 4'd0, 19'(DATA_BASE + 32'(4 * k))});
			else
				put_word(a, {op, r[26:0]});
			a = a + 32'd4;
		end
		for (int i = 0; i < 16; i++) begin
			put_word(a, {cpu_pkg::OP_ST, 4'(i), 4'd0, 19'(DUMP_BASE + 32'(4 * i))});
			a = a + 32'd4;
		end
		put_word(a, {cpu_pkg::OP_HALT, 27'd0});
		for (int i = 0; i < 16; i++)
			put_word(DATA_BASE + 32'(4 * i), $random(seed));
		n = 16 + RAND_LEN + 16 + 1;
	endtask

	task automatic serve_read();
		logic [31:0] a;
		repeat (rand_below(4)) @(negedge clk);
		a = araddr;
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		repeat (rand_below(4)) @(negedge clk);
		rdata = read_word(a);
		rvalid = 1'b1;
		@(negedge clk);
		rvalid = 1'b0;
	endtask

	// AW and W are accepted after their own random delays
	task automatic serve_write();
		logic [31:0] a;
		logic [31:0] d;
		int d_aw;
		int d_w;
		int cnt;
		logic aw_done;
		logic w_done;
		a = awaddr;
		d = wdata;
		d_aw = rand_below(4);
		d_w = rand_below(4);
		cnt = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			awready = !aw_done && (cnt >= d_aw);
			wready = !w_done && (cnt >= d_w);
			@(negedge clk);
			if (awready) aw_done = 1'b1;
			if (wready) w_done = 1'b1;
			cnt++;
		end
		awready = 1'b0;
		wready = 1'b0;
		mem_words[a[31:2]] = d;
		repeat (rand_below(4)) @(negedge clk);
		bvalid = 1'b1;
		@(negedge clk);
		bvalid = 1'b0;
	endtask

	always begin
		@(negedge clk);
		if (rst_n && arvalid)
			serve_read();
		else if (rst_n && awvalid)
			serve_write();
	end

	initial begin
		rst_n = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		arready = 1'b0;
		bvalid = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		bresp = bus_pkg::RESP_OKAY;
		rresp = bus_pkg::RESP_OKAY;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			build_program(prog_len);
			scoreboard_i.start_test();
			@(negedge clk);
			rst_n = 1'b0;
			repeat (2) @(negedge clk);
			scoreboard_i.check_reset();
			rst_n = 1'b1;
			// Worst case per instruction: fetch 11 cycles, execute 13
			limit = prog_len * (12 + 3 * 4) + 16;
			cycles = 0;
			while (!halted && cycles < limit) begin
				@(negedge clk);
				cycles++;
			end
			if (!halted) begin
				$display("Timeout: the CPU did not halt within %0d cycles in test %0d", limit, t);
				timed_out = 1'b1;
			end else begin
				// Idle time to catch any request after halt
				repeat (10) @(negedge clk);
				scoreboard_i.end_test(t);
			end
		end
		scoreboard_i.report();
		if (!timed_out && scoreboard_i.errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

// ==== files.f ====
design/cpu_pkg.sv
design/bus_pkg.sv
design/cpu_ifs.sv
design/alu.sv
design/reg_file.sv
design/datapath.sv
design/control_sequencer.sv
design/mem_bridge.sv
design/cpu_top.sv
verif/cpu_chk.sv
verif/cpu_scoreboard.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cpu_tb -Mdir obj_dir -f files.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Simulation failed"
	exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
echo "Simulation failed"
exit 1
